/* pool_array.f */
common/pool_pkg.sv
hw/pool_skew_stage.sv
hw/pool_ctrl.sv
pool_lane/pool_scratch_rf.sv
pool_lane/pool_lane.sv
hw/pool_out_credit.sv
hw/pool_array_top.sv
tests/tb_pool_array.sv

/* Makefile */
TOP = tb_pool_array

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f pool_array.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* tests/tb_pool_array.sv */
module tb_pool_array
    import pool_pkg::*;
();

    localparam int TILE_LEN = ROWS * ROW_LEN;
    localparam int WAIT_MAX = 1000; // cycles any single wait may take.

    logic              clk = 1'b0;
    logic              nrst;
    logic              start;
    pool_mode_e        mode;
    data_t [LANES-1:0] in_data;
    logic              credit_return = 1'b0;
    logic              busy;
    logic              out_valid;
    pool_result_t      out_data;

    logic [31:0]  lfsr = 32'h54db;
    data_t        tile [LANES][ROWS][ROW_LEN]; // the model's copy of the tile.
    pool_result_t got_q [$];                   // every result in order of arrival.
    int           returned = 0;                // credits handed back so far.
    logic         credit_on;
    int           errors;
    int           checks;
    int           tests;

    always #50 clk = ~clk;

    pool_array_top pool_array_top_i (
        .clk           (clk),
        .nrst          (nrst),
        .start         (start),
        .mode          (mode),
        .in_data       (in_data),
        .credit_return (credit_return),
        .busy          (busy),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    // ------------------------------------------------------------
    // downstream receiver
    // ------------------------------------------------------------
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
            got_q.push_back(out_data); // the send completes on the coming edge.
    end

    always @(posedge clk)
    begin
        #10;
        if (credit_on && returned < got_q.size())
        begin
            credit_return = 1'b1; // one credit back per cycle, never more than were spent.
            returned++;
        end
        else
            credit_return = 1'b0;
    end

    // ------------------------------------------------------------
    // stimulus and model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
    endfunction

    function automatic data_t random_sample();
        data_t v;
        v = '0;
        for (int i = 0; i < 16; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic fill_tile(input logic all_ones);
        for (int l = 0; l < LANES; l++)
            for (int r = 0; r < ROWS; r++)
                for (int c = 0; c < ROW_LEN; c++)
                    tile[l][r][c] = all_ones ? 16'hFFFF : random_sample();
    endtask

    // Result idx of lane l covers rows 2q, 2q+1 and columns 2p, 2p+1.
    function automatic data_t window_result(int l, int idx, pool_mode_e m);
        int q;
        int p;
        int s [4];
        int best;
        int sum;
        q    = idx / (ROW_LEN / 2);
        p    = idx % (ROW_LEN / 2);
        s[0] = int'(tile[l][2*q][2*p]);
        s[1] = int'(tile[l][2*q][2*p+1]);
        s[2] = int'(tile[l][2*q+1][2*p]);
        s[3] = int'(tile[l][2*q+1][2*p+1]);
        best = 0;
        sum  = 0;
        for (int i = 0; i < 4; i++)
        begin
            best = (s[i] > best) ? s[i] : best;
            sum  = sum + s[i];
        end
        if (m == POOL_MAX)
            return data_t'(best);
        return data_t'(sum / 4); // remainder dropped.
    endfunction

    task automatic abort_run(string what);
        $display("timeout: %s", what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0)
        begin
            @(posedge clk);
            #10;
            n++;
            if (n == WAIT_MAX)
                abort_run("busy stayed high, the tile never drained");
        end
    endtask

    task automatic set_credit_policy(input logic on);
        @(negedge clk);
        credit_on = on;
    endtask

    // Feeds one tile with the systolic skew, lane j one cycle behind lane j-1.
    task automatic run_tile(pool_mode_e m, int restart_at);
        int k;
        wait_idle();
        @(posedge clk);
        #10;
        start = 1'b1;
        mode  = m;
        for (int c = 0; c < TILE_LEN + LANES; c++)
        begin
            @(posedge clk);
            #10;
            if (c == 0)
                check_flag("busy", busy, 1'b1);
            start = (c == restart_at);
            mode  = (m == POOL_MAX) ? POOL_AVG : POOL_MAX; // the latched mode must hold.
            for (int j = 0; j < LANES; j++)
            begin
                k          = c - j;
                in_data[j] = (k >= 0 && k < TILE_LEN) ? tile[j][k / ROW_LEN][k % ROW_LEN] : '0;
            end
        end
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic check_result(pool_result_t got, pool_result_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t out_data: got lane %0d value %h, expected lane %0d value %h",
                     $time, got.lane, got.value, exp.lane, exp.value);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // With the skew every lane has a result ready on its turn, so the
    // merged stream visits lanes 0, 1, 2, 3 over and over.
    task automatic check_tile(int base, pool_mode_e m);
        int           n;
        pool_result_t exp;
        for (int i = base; i < got_q.size(); i++)
        begin
            n = i - base;
            if (n < LANES * BUF_DEPTH)
            begin
                exp.lane  = lane_t'(n % LANES);
                exp.value = window_result(n % LANES, n / LANES, m);
                check_result(got_q[i], exp);
            end
        end
        checks++;
        if (got_q.size() - base != LANES * BUF_DEPTH)
        begin
            errors++;
            $display("tile delivered %0d results, expected %0d",
                     got_q.size() - base, LANES * BUF_DEPTH);
        end
    endtask

    task automatic report_test(string name, int err_before);
        tests++;
        if (errors == err_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic pool_tile(input logic all_ones, pool_mode_e m, int restart_at);
        int base;
        fill_tile(all_ones);
        base = got_q.size();
        run_tile(m, restart_at);
        wait_idle();
        check_tile(base, m);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset_idle();
        int e;
        e = errors;
        repeat (10)
        begin
            @(posedge clk);
            #10;
            check_flag("busy", busy, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
        end
        report_test("reset_idle", e);
    endtask

    task automatic test_max_lfsr();
        int e;
        e = errors;
        pool_tile(1'b0, POOL_MAX, -1);
        report_test("max_lfsr", e);
    endtask

    task automatic test_avg_mean();
        int e;
        e = errors;
        pool_tile(1'b1, POOL_AVG, -1); // all ones also stresses the partial width.
        pool_tile(1'b0, POOL_AVG, -1);
        report_test("avg_mean", e);
    endtask

    task automatic test_credit_stall();
        int e;
        int base;
        e = errors;
        set_credit_policy(1'b0);
        fill_tile(1'b0);
        base = got_q.size();
        run_tile(POOL_MAX, -1);
        repeat (20)
        begin
            @(posedge clk);
            #10;
            check_flag("out_valid", out_valid, 1'b0);
        end
        checks++;
        if (got_q.size() - base != CREDIT_MAX)
        begin
            errors++;
            $display("%0d results sent without credit returns, expected %0d",
                     got_q.size() - base, CREDIT_MAX);
        end
        set_credit_policy(1'b1);
        wait_idle();
        check_tile(base, POOL_MAX);
        report_test("credit_stall", e);
    endtask

    task automatic test_start_while_busy();
        int e;
        e = errors;
        pool_tile(1'b0, POOL_MAX, 5);  // a second start lands while busy.
        pool_tile(1'b0, POOL_AVG, -1);
        report_test("start_while_busy", e);
    endtask

    task automatic test_back_to_back();
        int e;
        e = errors;
        pool_tile(1'b0, POOL_MAX, -1);
        pool_tile(1'b0, POOL_AVG, -1);
        report_test("back_to_back", e);
    endtask

    initial
    begin
        nrst      = 1'b0;
        start     = 1'b0;
        mode      = POOL_MAX;
        in_data   = '0;
        credit_on = 1'b1;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (5) @(posedge clk);
        #10;
        nrst = 1'b1;

        test_reset_idle();
        test_max_lfsr();
        test_avg_mean();
        test_credit_stall();
        test_start_while_busy();
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* hw/pool_array_top.sv */
module pool_array_top
    import pool_pkg::*;
(
    input  logic              clk,
    input  logic              nrst,
    input  logic              start,
    input  pool_mode_e        mode,
    input  data_t [LANES-1:0] in_data,
    input  logic              credit_return,
    output logic              busy,
    output logic              out_valid,
    output pool_result_t      out_data
);

    pool_ctrl_t        lane_ctrl [LANES]; // control word as seen by each lane.
    logic [LANES-1:0]  lane_valid;
    data_t [LANES-1:0] lane_value;
    logic              drained;

    pool_ctrl ctrl_i (
        .clk     (clk),
        .nrst    (nrst),
        .start   (start),
        .mode    (mode),
        .drained (drained),
        .ctrl    (lane_ctrl[0]),
        .busy    (busy)
    );

    // ----------------------------------------------------------
    // skew chain and pooling lanes
    // ----------------------------------------------------------
    for (genvar j = 1; j < LANES; j++)
    begin : g_skew
        pool_skew_stage skew_i (
            .clk      (clk),
            .nrst     (nrst),
            .ctrl_in  (lane_ctrl[j-1]),
            .ctrl_out (lane_ctrl[j])
        );
    end

    for (genvar j = 0; j < LANES; j++)
    begin : g_lane
        pool_lane lane_i (
            .clk          (clk),
            .nrst         (nrst),
            .ctrl         (lane_ctrl[j]),
            .sample       (in_data[j]),
            .result_valid (lane_valid[j]),
            .result_value (lane_value[j])
        );
    end

    pool_out_credit out_i (
        .clk           (clk),
        .nrst          (nrst),
        .push          (lane_valid),
        .push_value    (lane_value),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .drained       (drained)
    );

endmodule

/* hw/pool_out_credit.sv */
module pool_out_credit
    import pool_pkg::*;
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic [LANES-1:0]         push,
    input  data_t [LANES-1:0]        push_value,
    input  logic                     credit_return,
    output logic                     out_valid,
    output pool_result_t             out_data,
    output logic                     drained
);

    typedef logic [$clog2(BUF_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] cnt_t;

    data_t            fifo_mem [LANES][BUF_DEPTH];
    ptr_t             wr_ptr [LANES];
    ptr_t             rd_ptr [LANES];
    cnt_t             fill [LANES];
    logic [LANES-1:0] empty;
    logic [LANES-1:0] pop;
    lane_t            last_lane; // lane that sent most recently.
    lane_t            sel_lane;
    logic             sel_found;
    credit_t          credit;

    // ----------------------------------------------------------
    // round-robin pick of the next non-empty lane
    // ----------------------------------------------------------
    always_comb
    begin
        int idx;
        sel_found = 1'b0;
        sel_lane  = last_lane;
        for (int i = 1; i <= LANES; i++)
        begin
            idx = (int'(last_lane) + i) % LANES;
            if (!sel_found && !empty[idx])
            begin
                sel_found = 1'b1;
                sel_lane  = lane_t'(idx);
            end
        end
    end

    assign out_valid      = sel_found && (credit != '0); // a send needs a credit in hand.
    assign out_data.lane  = sel_lane;
    assign out_data.value = fifo_mem[sel_lane][rd_ptr[sel_lane]];
    assign drained        = &empty;

    // ----------------------------------------------------------
    // per-lane result FIFOs
    // ----------------------------------------------------------
    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            empty[l] = (fill[l] == '0);
            pop[l]   = out_valid && (sel_lane == lane_t'(l));
        end
    end

    always_ff @(posedge clk)
    begin
        for (int l = 0; l < LANES; l++)
            if (push[l])
                fifo_mem[l][wr_ptr[l]] <= push_value[l];
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                wr_ptr[l] <= '0;
                rd_ptr[l] <= '0;
                fill[l]   <= '0;
            end
            last_lane <= lane_t'(LANES - 1); // lane 0 goes first.
            credit    <= credit_t'(CREDIT_MAX);
        end
        else
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (push[l])
                    wr_ptr[l] <= wr_ptr[l] + ptr_t'(1);
                if (pop[l])
                    rd_ptr[l] <= rd_ptr[l] + ptr_t'(1);
                if (push[l] && !pop[l])
                    fill[l] <= fill[l] + cnt_t'(1);
                else if (!push[l] && pop[l])
                    fill[l] <= fill[l] - cnt_t'(1);
            end
            if (out_valid)
                last_lane <= sel_lane;
            // a return and a send in the same cycle leave the count alone.
            if (out_valid && !credit_return)
                credit <= credit - credit_t'(1);
            else if (!out_valid && credit_return && credit != credit_t'(CREDIT_MAX))
                credit <= credit + credit_t'(1);
        end
    end

endmodule

/* pool_lane/pool_lane.sv */
module pool_lane
    import pool_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  pool_ctrl_t ctrl,
    input  data_t      sample,
    output logic       result_valid,
    output data_t      result_value
);

    acc_t  sample_w;  // fresh sample widened to the partial width.
    acc_t  fb_q;      // first sample of the current pair.
    acc_t  mux_out;
    acc_t  pair;      // both samples of the pair merged.
    acc_t  row_part;  // partial from the top row, or neutral in a top row.
    acc_t  window;    // pair merged with its top-row partial.
    acc_t  rd_data;
    data_t result_d;

    function automatic acc_t combine(acc_t a, acc_t b, pool_mode_e m);
        if (m == POOL_MAX)
            return (a > b) ? a : b;
        return a + b; // cannot overflow for four 16-bit samples.
    endfunction

    // ----------------------------------------------------------
    // input mux, feedback register and combiner
    // ----------------------------------------------------------
    assign sample_w = acc_t'(sample);
    assign mux_out  = ctrl.first_of_pair ? sample_w : fb_q;
    assign pair     = combine(fb_q, sample_w, ctrl.mode);
    assign row_part = ctrl.first_row ? '0 : rd_data; // zero is neutral for max and sum.
    assign window   = combine(pair, row_part, ctrl.mode);
    assign result_d = (ctrl.mode == POOL_AVG) ? data_t'(window >> 2) : data_t'(window);

    always_ff @(posedge clk)
    begin
        if (ctrl.take_in)
            fb_q <= mux_out; // loads on the first sample, holds on the second.
    end

    pool_scratch_rf scratch_i (
        .clk     (clk),
        .nrst    (nrst),
        .wr_en   (ctrl.wr_partial),
        .wr_addr (ctrl.wr_addr),
        .wr_data (window),
        .rd_addr (ctrl.rd_addr),
        .rd_data (rd_data)
    );

    // ----------------------------------------------------------
    // result capture
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            result_valid <= 1'b0;
        else
            result_valid <= ctrl.emit; // one-cycle pulse per window.
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.emit)
            result_value <= result_d;
    end

endmodule

/* pool_lane/pool_scratch_rf.sv */
module pool_scratch_rf
    import pool_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     wr_en,
    input  rf_addr_t wr_addr,
    input  acc_t     wr_data,
    input  rf_addr_t rd_addr,
    output acc_t     rd_data
);

    // ----------------------------------------------------------
    // row partial storage
    // ----------------------------------------------------------
    // Top-row pair partials wait here until the matching bottom-row
    // pair arrives. Each pair column owns one entry.

    acc_t mem [RF_DEPTH];

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < RF_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            mem[wr_addr] <= wr_data; // synchronous write.
        end
    end

    // asynchronous read sees the value before any write on this edge.
    assign rd_data = mem[rd_addr];

endmodule

/* hw/pool_ctrl.sv */
module pool_ctrl
    import pool_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       start,
    input  pool_mode_e mode,
    input  logic       drained,
    output pool_ctrl_t ctrl,
    output logic       busy
);

    typedef logic [$clog2(ROW_LEN)-1:0] col_t;
    typedef logic [$clog2(ROWS)-1:0]    row_t;
    typedef logic [$clog2(LANES+1)-1:0] drain_t;

    ctrl_state_e state;
    col_t        col_cnt;   // sample position within the current row.
    row_t        row_cnt;   // row within the tile.
    drain_t      drain_cnt; // cycles spent waiting for the skew chain.
    pool_mode_e  mode_q;    // mode held for the whole tile.
    logic        run;
    logic        last_col;
    logic        last_row;

    assign run      = (state == RUN);
    assign last_col = (col_cnt == col_t'(ROW_LEN - 1));
    assign last_row = (row_cnt == row_t'(ROWS - 1));
    assign busy     = (state != IDLE);

    // ----------------------------------------------------------
    // lane-0 control word
    // ----------------------------------------------------------
    always_comb
    begin
        ctrl               = '0;
        ctrl.take_in       = run;
        ctrl.first_of_pair = run & ~col_cnt[0];             // even column opens a pair.
        ctrl.first_row     = ~row_cnt[0];
        ctrl.wr_partial    = run & col_cnt[0] & ~row_cnt[0]; // top row closes a pair.
        ctrl.emit          = run & col_cnt[0] & row_cnt[0];  // bottom row closes a window.
        ctrl.rd_addr       = rf_addr_t'(col_cnt >> 1);       // one entry per pair column.
        ctrl.wr_addr       = rf_addr_t'(col_cnt >> 1);
        ctrl.mode          = mode_q;
    end

    // ----------------------------------------------------------
    // tile sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state     <= IDLE;
            col_cnt   <= '0;
            row_cnt   <= '0;
            drain_cnt <= '0;
            mode_q    <= POOL_MAX;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        state   <= RUN;
                        col_cnt <= '0;
                        row_cnt <= '0;
                        mode_q  <= mode; // latched once per tile.
                    end
                end
                RUN:
                begin
                    col_cnt <= col_cnt + col_t'(1);
                    if (last_col)
                    begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + row_t'(1);
                        if (last_row)
                        begin
                            row_cnt   <= '0;
                            drain_cnt <= '0;
                            state     <= DRAIN;
                        end
                    end
                end
                DRAIN:
                begin
                    // the last lane trails lane 0 by LANES-1 cycles plus its result register.
                    if (drain_cnt != drain_t'(LANES))
                        drain_cnt <= drain_cnt + drain_t'(1);
                    else if (drained)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

/* hw/pool_skew_stage.sv */
module pool_skew_stage
    import pool_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  pool_ctrl_t ctrl_in,
    output pool_ctrl_t ctrl_out
);

    // ----------------------------------------------------------
    // one cycle of systolic skew
    // ----------------------------------------------------------
    // The neighbour to the right sees its column data one cycle later,
    // so its control word is the left lane's word delayed by one edge.

    pool_ctrl_t ctrl_q;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            ctrl_q <= '0; // no take_in or emit leaks out of reset.
        end
        else
        begin
            ctrl_q <= ctrl_in;
        end
    end

    assign ctrl_out = ctrl_q;

endmodule

/* common/pool_pkg.sv */
package pool_pkg;

    // ----------------------------------------------------------
    // array geometry and buffering
    // ----------------------------------------------------------
    localparam int LANES      = 4;  // one lane per array column.
    localparam int ROW_LEN    = 8;  // samples per row, even and at most 32.
    localparam int ROWS       = 4;  // rows per tile, even.
    localparam int RF_DEPTH   = 16; // scratch entries per lane.
    localparam int BUF_DEPTH  = 8;  // one full tile of results per lane.
    localparam int CREDIT_MAX = 4;  // credits granted by the receiver after reset.

    // ----------------------------------------------------------
    // vector types
    // ----------------------------------------------------------
    typedef logic [15:0] data_t;    // unsigned sample or pooled result.
    typedef logic [17:0] acc_t;     // wide enough for the sum of four samples.
    typedef logic [3:0]  rf_addr_t; // scratch file address.
    typedef logic [1:0]  lane_t;    // lane index carried with each result.
    typedef logic [2:0]  credit_t;  // downstream credit count.

    typedef enum logic
    {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_mode_e;

    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } ctrl_state_e;

    // Control word handed from lane to lane through the skew chain.
    typedef struct packed
    {
        logic       take_in;       // a sample is valid this cycle.
        logic       first_of_pair; // fresh sample, not the feedback value.
        logic       first_row;     // top row of a window pair.
        logic       wr_partial;    // store the pair partial in scratch.
        logic       emit;          // a window result completes this cycle.
        rf_addr_t   rd_addr;
        rf_addr_t   wr_addr;
        pool_mode_e mode;
    } pool_ctrl_t;

    typedef struct packed
    {
        lane_t lane;
        data_t value;
    } pool_result_t;

endpackage
